//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP = classifierTb
FILELIST = vlog.f
BUILD_DIR = obj_dir
PASS_MSG = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/argmaxSelect.sv
`default_nettype none

module argmaxSelect
	import nnPkg::*;
#(
	parameter int NumClasses = nnPkg::NumClasses
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input data_t scores [NumClasses],
	output logic outValid,
	output logic [ClassWidth-1:0] bestClass,
	output data_t bestScore
);

	logic [ClassWidth-1:0] winIdx;
	data_t winScore;

	// strict compare keeps the lowest index on a tie
	always_comb
	begin
		winIdx = '0;
		winScore = scores[0];
		for (int c = 1; c < NumClasses; c++)
		begin
			if (scores[c] > winScore)
			begin
				winIdx = ClassWidth'(c);
				winScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid)
		begin
			bestClass <= winIdx;
			bestScore <= winScore;
		end
	end

endmodule

`default_nettype wire

//--- logic/classifierTop.sv
`default_nettype none

module classifierTop
	import nnPkg::*;
#(
	parameter int NumInputs = nnPkg::NumInputs,
	parameter int NumHidden = nnPkg::NumHidden,
	parameter int NumClasses = nnPkg::NumClasses
)
(
	input logic clk,
	input logic reset,
	input logic featureValid,
	input data_t featureData,
	output logic resultValid,
	output logic [ClassWidth-1:0] resultClass,
	output data_t resultScore
);

	logic frameValid;
	data_t frameVector [NumInputs];
	logic hiddenValid;
	data_t hiddenVector [NumHidden];
	logic scoreValid;
	data_t scoreVector [NumClasses];

	featureCollector #(
		.NumInputs(NumInputs)
	) uCollector (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.featureData(featureData),
		.frameValid(frameValid),
		.frameVector(frameVector)
	);

	////////////////////////////////////////////////////////////////////////////
	// two dense layers, 2 cycles each

	denseLayer #(
		.NumIn(NumInputs),
		.NumOut(NumHidden),
		.UseRelu(1'b1),
		.LayerSel(HiddenLayer)
	) uHidden (
		.clk(clk),
		.reset(reset),
		.inValid(frameValid),
		.inVector(frameVector),
		.outValid(hiddenValid),
		.outVector(hiddenVector)
	);

	denseLayer #(
		.NumIn(NumHidden),
		.NumOut(NumClasses),
		.UseRelu(1'b0), // signed scores
		.LayerSel(OutputLayer)
	) uOutput (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inVector(hiddenVector),
		.outValid(scoreValid),
		.outVector(scoreVector)
	);

	argmaxSelect #(
		.NumClasses(NumClasses)
	) uArgmax (
		.clk(clk),
		.reset(reset),
		.inValid(scoreValid),
		.scores(scoreVector),
		.outValid(resultValid),
		.bestClass(resultClass),
		.bestScore(resultScore)
	);

endmodule

`default_nettype wire

//--- logic/denseLayer.sv
`default_nettype none

module denseLayer
	import nnPkg::*;
#(
	parameter int NumIn = NumInputs,
	parameter int NumOut = NumHidden,
	parameter bit UseRelu = 1'b1,
	parameter int LayerSel = HiddenLayer
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input data_t inVector [NumIn],
	output logic outValid,
	output data_t outVector [NumOut]
);

	logic [1:0] validPipe; // matches the neuron latency

	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[0], inValid};
	end

	assign outValid = validPipe[1];

	for (genvar n = 0; n < NumOut; n++)
	begin : gNeuron
		data_t rowWeights [NumIn];

		for (genvar i = 0; i < NumIn; i++)
		begin : gWeight
			assign rowWeights[i] = weightAt(LayerSel, n, i);
		end

		neuronNode #(
			.NumIn(NumIn),
			.UseRelu(UseRelu)
		) uNode (
			.clk(clk),
			.reset(reset),
			.inValid(inValid),
			.inVector(inVector),
			.weights(rowWeights),
			.bias(biasAt(LayerSel, n)),
			.outValid(), // layer valid comes from validPipe
			.outValue(outVector[n])
		);
	end

endmodule

`default_nettype wire

//--- logic/featureCollector.sv
`default_nettype none

module featureCollector
	import nnPkg::*;
#(
	parameter int NumInputs = nnPkg::NumInputs
)
(
	input logic clk,
	input logic reset,
	input logic featureValid,
	input data_t featureData,
	output logic frameValid,
	output data_t frameVector [NumInputs]
);

	localparam int CountWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;

	logic [CountWidth-1:0] count;
	logic lastFeature;
	data_t shiftReg [NumInputs];
	data_t nextShift [NumInputs];

	assign lastFeature = (count == CountWidth'(NumInputs - 1));

	// oldest feature ends up at index 0
	always_comb
	begin
		for (int i = 0; i < NumInputs - 1; i++)
			nextShift[i] = shiftReg[i + 1];
		nextShift[NumInputs - 1] = featureData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0; // partial frame dropped
			frameValid <= 1'b0;
		end
		else
		begin
			frameValid <= featureValid && lastFeature;
			if (featureValid)
				count <= lastFeature ? '0 : count + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (featureValid)
			shiftReg <= nextShift;
		if (featureValid && lastFeature)
			frameVector <= nextShift; // held until next frame completes
	end

	countInRange: assert property (@(posedge clk) disable iff (reset)
		{1'b0, count} < (CountWidth + 1)'(NumInputs));

endmodule

`default_nettype wire

//--- logic/neuronNode.sv
`default_nettype none

module neuronNode
	import nnPkg::*;
#(
	parameter int NumIn = NumInputs,
	parameter bit UseRelu = 1'b1
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input data_t inVector [NumIn],
	input data_t weights [NumIn],
	input data_t bias,
	output logic outValid,
	output data_t outValue
);

	data_t inReg [NumIn];
	logic validReg;
	acc_t sum;

	////////////////////////////////////////////////////////////////////////////
	// stage 1, input register

	always_ff @(posedge clk)
	begin
		if (inValid)
			inReg <= inVector;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validReg <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			validReg <= inValid;
			outValid <= validReg;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2, full width MAC and rescale

	// bias is aligned to the Q4 products
	always_comb
	begin
		sum = acc_t'(bias) <<< FracBits;
		for (int i = 0; i < NumIn; i++)
			sum += acc_t'(inReg[i]) * acc_t'(weights[i]);
	end

	always_ff @(posedge clk)
	begin
		if (validReg)
			outValue <= quantize(sum, UseRelu);
	end

	validLatency: assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##2 outValid);

	noStrayValid: assert property (@(posedge clk) disable iff (reset)
		outValid |-> $past(inValid, 2));

endmodule

`default_nettype wire

//--- logic/nnPkg.sv
`default_nettype none

package nnPkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and counts

	localparam int DataWidth = 8;
	localparam int AccWidth = 24; // 30 full products plus bias, with headroom
	localparam int FracBits = 4;

	localparam int NumInputs = 30;
	localparam int NumHidden = 8;
	localparam int NumClasses = 4;
	localparam int ClassWidth = 2;

	localparam int MaxData = 2 ** (DataWidth - 1) - 1;
	localparam int MinData = -(2 ** (DataWidth - 1));

	// layer select for the table lookups
	localparam int HiddenLayer = 0;
	localparam int OutputLayer = 1;

	typedef logic signed [DataWidth-1:0] data_t;
	typedef logic signed [AccWidth-1:0] acc_t;

`include "nnWeights.svh"

	////////////////////////////////////////////////////////////////////////////
	// quantization and lookups

	// rescale by FracBits, then clamp to the data range
	function automatic data_t quantize(acc_t acc, bit relu);
		acc_t shifted;
		shifted = acc >>> FracBits;
		if (relu && shifted < 0)
			return '0;
		if (shifted > acc_t'(MaxData))
			return data_t'(MaxData);
		if (shifted < acc_t'(MinData))
			return data_t'(MinData);
		return data_t'(shifted);
	endfunction

	function automatic data_t weightAt(int layerSel, int neuron, int idx);
		if (layerSel == HiddenLayer)
			return hiddenWeights[neuron][idx];
		return outWeights[neuron][idx];
	endfunction

	function automatic data_t biasAt(int layerSel, int neuron);
		if (layerSel == HiddenLayer)
			return hiddenBias[neuron];
		return outBias[neuron];
	endfunction

endpackage

`default_nettype wire

//--- logic/nnWeights.svh
`ifndef NN_WEIGHTS_SVH
`define NN_WEIGHTS_SVH

	// hidden layer, one row of Q4 weights per neuron
	// first input pulls every neuron down
	localparam data_t hiddenWeights [NumHidden][NumInputs] = '{
		'{ -20,   7,  12,  -3,   5,  14,  -9,   2, -11,  18,   4,   6,  -7,  10, -15,
		     3,   9,  -5,   1,  -2,  13,  -8,   6,  11,  -4,  16,  -6,   2,   3,   8},
		'{ -18,  -6,   9,  15, -12,   3,   8,  -4,   7, -10,  11,   2, -13,   5,   9,
		    -7,   4,  12,  -3,   6,  -9,  14,   1,  -5,   8,  -2,  10, -11,   7,  -1},
		'{ -22,  11,  -4,   6,   9, -13,   2,  15,  -6,   3,  -8,  12,   4, -10,   7,
		    13,  -5,   2,   9, -14,   6,   3,  -7,  10,  -1,   5, -12,   8,   4,  -3},
		'{ -19,  -9,  14,   2,  -5,   8,  11, -12,   3,   6,  -2,  -7,  15,   1, -10,
		     4,  12,  -8,   5,   7,  -3, -11,   9,   2,  -6,  14,   3,  -4,  10, -13},
		'{ -24,   5, -11,  10,   3,  -6,  13,   7,  -9,  12,   1,  -4,   8, -14,   6,
		    -2,  11,   3, -10,   9,   5,  -7,  12,  -3,   6,  -1,  13,  -5,   2,   9},
		'{ -17,  13,   3,  -8,  11,   4,  -5,   9,  14,  -2, -12,   7,   1,   6, -11,
		     8,  -3,  10,  -6,   2,  15,   4,  -9, -13,   5,   7,  -1,  11,  -4,   3},
		'{ -21,  -3,   6,  12,  -7,  10,  -1, -14,   5,   9,  13, -10,   2,   8,   4,
		   -12,   7,  -2,  14,  -8,   1,  10,   3,   6, -11,  -4,   9,  -6,  12,   2},
		'{ -23,   8,  -7,   4,  14,  -1,   6,  -3,  12,  -9,   5,  10, -12,   3,  13,
		     6, -10,   8,   2,  11,  -4,  -6,  13,  -2,   7,   9, -14,   4,  -8,  10}
	};

	localparam data_t hiddenBias [NumHidden] = '{3, -2, 5, 0, -4, 7, 1, -1};

	// output layer, one row per class
	localparam data_t outWeights [NumClasses][NumHidden] = '{
		'{  14,  -6,   9,   3, -11,   5,   8,  -4},
		'{  -5,  12,  -3,  10,   6,  -9,   4,   7},
		'{   7,   4, -10,  -6,  13,   2,  -5,  11},
		'{  -8,   9,   6, -12,   3,  10,  -7,   5}
	};

	// classes 1 and 2 tie when all hidden outputs are zero
	localparam data_t outBias [NumClasses] = '{4, 11, 11, -6};

`endif

//--- testbench/classifierTb.sv
`default_nettype none

module classifierTb
	import nnPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NumRows = 14;
	localparam int Latency = 6; // last strobe to resultValid
	localparam int CycleLimit = 16 + NumRows * (NumInputs * 3 + 10) + 50;

	logic clk = 1'b0;
	logic reset;
	logic featureValid;
	data_t featureData;
	logic resultValid;
	logic [ClassWidth-1:0] resultClass;
	data_t resultScore;

	// stimulus table with expected results
	data_t rowFeat [NumRows][NumInputs];
	bit rowGaps [NumRows];
	bit rowResetMid [NumRows];
	logic [ClassWidth-1:0] expClass [NumRows];
	data_t expScore [NumRows];

	int pendingRow [$];
	int strobeCycle [$];
	int cycleCount = 0;

	classifierTop #(
		.NumInputs(NumInputs),
		.NumHidden(NumHidden),
		.NumClasses(NumClasses)
	) DUT (
		.clk(clk),
		.reset(reset),
		.featureValid(featureValid),
		.featureData(featureData),
		.resultValid(resultValid),
		.resultClass(resultClass),
		.resultScore(resultScore)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// reference model

	function automatic void computeExpected(int r);
		int acc;
		data_t hidden [NumHidden];
		data_t score;
		data_t best;
		int bestIdx;
		for (int n = 0; n < NumHidden; n++)
		begin
			acc = int'(hiddenBias[n]) * (2 ** FracBits);
			for (int i = 0; i < NumInputs; i++)
				acc += int'(rowFeat[r][i]) * int'(hiddenWeights[n][i]);
			hidden[n] = quantize(acc_t'(acc), 1'b1);
		end
		best = '0;
		bestIdx = 0;
		for (int c = 0; c < NumClasses; c++)
		begin
			acc = int'(outBias[c]) * (2 ** FracBits);
			for (int n = 0; n < NumHidden; n++)
				acc += int'(hidden[n]) * int'(outWeights[c][n]);
			score = quantize(acc_t'(acc), 1'b0);
			if (c == 0 || score > best) // lowest index kept on a tie
			begin
				best = score;
				bestIdx = c;
			end
		end
		expClass[r] = ClassWidth'(bestIdx);
		expScore[r] = best;
	endfunction

	task automatic buildTable();
		for (int r = 0; r < NumRows; r++)
		begin
			rowGaps[r] = (r >= 9 && r <= 12);
			rowResetMid[r] = (r == 13);
			for (int i = 0; i < NumInputs; i++)
			begin
				case (r)
					0: rowFeat[r][i] = '0;
					1: rowFeat[r][i] = data_t'(127);
					2: rowFeat[r][i] = data_t'(-128);
					3: rowFeat[r][i] = (i % 2 == 0) ? data_t'(127) : data_t'(-128);
					4: rowFeat[r][i] = (i == 0) ? data_t'(127) : '0; // every hidden sum clipped
					9, 10, 11, 12: rowFeat[r][i] = rowFeat[r - 4][i]; // gapped copies
					default: rowFeat[r][i] = data_t'($urandom);
				endcase
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks and monitor

	task automatic checkValue(string what, integer actual, integer expected);
		if (actual !== expected)
		begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic checkResult();
		int r;
		int sent;
		if (pendingRow.size() == 0)
		begin
			$display("a result arrived with no frame outstanding");
			$display("Finished with errors");
			$fatal(1, "unexpected result");
		end
		else
		begin
			r = pendingRow.pop_front();
			sent = strobeCycle.pop_front();
			checkValue($sformatf("row %0d class", r), resultClass, expClass[r]);
			checkValue($sformatf("row %0d score", r), resultScore, expScore[r]);
			// seen one edge after it rises
			checkValue($sformatf("row %0d latency", r), cycleCount - sent, Latency + 1);
		end
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit)
		begin
			$display("no result arrived before the cycle limit");
			$display("Finished with errors");
			$fatal(1, "cycle limit reached");
		end
		else if (resultValid)
			checkResult();
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic idleCycles(int n);
		repeat (n)
		begin
			@(posedge clk);
			featureValid <= 1'b0;
		end
	endtask

	task automatic waitDrained();
		while (pendingRow.size() != 0)
			idleCycles(1);
	endtask

	task automatic sendFrame(int r);
		int gap;
		for (int i = 0; i < NumInputs; i++)
		begin
			if (rowGaps[r])
			begin
				gap = int'($urandom % 3);
				idleCycles(gap);
			end
			@(posedge clk);
			featureValid <= 1'b1;
			featureData <= rowFeat[r][i];
		end
		pendingRow.push_back(r);
		strobeCycle.push_back(cycleCount);
	endtask

	// reset drops a partial frame
	task automatic resetMidFrame();
		waitDrained();
		for (int i = 0; i < NumInputs / 2 - 3; i++)
		begin
			@(posedge clk);
			featureValid <= 1'b1;
			featureData <= data_t'($urandom);
		end
		@(posedge clk);
		featureValid <= 1'b0;
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	endtask

	initial
	begin
		reset = 1'b1;
		featureValid = 1'b0;
		featureData = '0;
		void'($urandom(32'h75e8));
		buildTable();
		for (int r = 0; r < NumRows; r++)
			computeExpected(r);

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		idleCycles(20); // resultValid must stay low here

		for (int r = 0; r < NumRows; r++)
		begin
			if (rowResetMid[r])
				resetMidFrame();
			sendFrame(r);
		end
		idleCycles(1);
		waitDrained();
		idleCycles(10);

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/nnPkg.sv
logic/featureCollector.sv
logic/neuronNode.sv
logic/denseLayer.sv
logic/argmaxSelect.sv
logic/classifierTop.sv
testbench/classifierTb.sv
